// ==== sim.f ====
+incdir+.
i2c_cmd_pkg.sv
init_seq_pkg.sv
init_rom.sv
init_sequencer.sv
i2c_cmd_out.sv
i2c_init.sv
tb_i2c_init.sv

// ==== tb_i2c_init.sv ====
// self-checking testbench for the audio board I2C init sequencer
`timescale 1ns/1ps
`default_nettype none

module tb_i2c_init;

    import i2c_cmd_pkg::*;
    import init_seq_pkg::*;

    `include "init_table.svh"

    localparam int TABLE_LEN      = 43;
    localparam int BOOST_ENTRY    = 41;
    localparam int BOOST_RESTART  = 39;
    localparam int RESET_CYCLES   = 4;
    localparam int NUM_ROWS       = 7;
    localparam int HOLD_CYCLES    = 30;
    localparam int TIMEOUT_CYCLES = TABLE_LEN * NUM_ROWS * 8 + RESET_CYCLES;

    // what a row does to the DUT inputs
    typedef enum logic [1:0] {
        ACT_PULSE = 2'd0,
        ACT_HOLD  = 2'd1,
        ACT_BOOST = 2'd2
    } action_e;

    typedef struct packed {
        action_e    action;
        logic       level;
        logic       rand_ready;
        logic [5:0] first;
    } stim_row_t;

    // action, boost level, random ready, first table entry
    localparam stim_row_t ROWS [NUM_ROWS] = '{
        '{ACT_PULSE, 1'b0, 1'b0, 6'd0},
        '{ACT_PULSE, 1'b0, 1'b1, 6'd0},
        '{ACT_BOOST, 1'b1, 1'b0, 6'd39},
        '{ACT_PULSE, 1'b0, 1'b0, 6'd0},
        '{ACT_BOOST, 1'b0, 1'b1, 6'd39},
        '{ACT_HOLD,  1'b0, 1'b0, 6'd0},
        '{ACT_PULSE, 1'b0, 1'b1, 6'd0}
    };

    logic      clk;
    logic      rst;
    logic      init_start;
    logic      mic_boost;
    i2c_cmd_t  cmd;
    logic      cmd_valid;
    logic      cmd_ready;
    i2c_byte_t data;
    logic      data_valid;
    logic      data_ready;
    logic      data_last;
    logic      busy;

    integer      seed;
    logic [31:0] rnd;
    logic        rand_ready;
    logic        boost_level;
    logic        stop_seen;
    int          error_count;
    int          tests_run;
    int          tests_failed;
    int          cycle_count;

    // payload hold tracking
    logic      cmd_held;
    logic      data_held;
    i2c_cmd_t  cmd_saved;
    i2c_byte_t data_saved;

    i2c_cmd_t  exp_cmds [$];
    i2c_byte_t exp_bytes [$];
    i2c_cmd_t  got_cmds [$];
    i2c_byte_t got_bytes [$];

    i2c_init #(
        .TABLE_LEN     (TABLE_LEN),
        .BOOST_ENTRY   (BOOST_ENTRY),
        .BOOST_RESTART (BOOST_RESTART)
    ) UUT (
        .clk        (clk),
        .rst        (rst),
        .init_start (init_start),
        .mic_boost  (mic_boost),
        .cmd        (cmd),
        .cmd_valid  (cmd_valid),
        .cmd_ready  (cmd_ready),
        .data       (data),
        .data_valid (data_valid),
        .data_ready (data_ready),
        .data_last  (data_last),
        .busy       (busy)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_cmd(input string name, input i2c_cmd_t got, input i2c_cmd_t exp);
        if (got !== exp) begin
            $display("FAIL %s got %h expected %h", name, got, exp);
            error_count++;
        end
    endtask

    task automatic check_byte(input string name, input i2c_byte_t got, input i2c_byte_t exp);
        if (got !== exp) begin
            $display("FAIL %s got %h expected %h", name, got, exp);
            error_count++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAIL %s got %h expected %h", name, got, exp);
            error_count++;
        end
    endtask

    // master side ready, random or always high
    always @(negedge clk) begin
        if (rand_ready) begin
            rnd = $random(seed);
            cmd_ready  <= rnd[0];
            data_ready <= rnd[1];
        end else begin
            cmd_ready  <= 1'b1;
            data_ready <= 1'b1;
        end
    end

    // collect transfers, watch held payloads
    always @(posedge clk) begin
        if (rst) begin
            cmd_held  = 1'b0;
            data_held = 1'b0;
        end else begin
            if (cmd_held && !cmd_valid) begin
                $display("cmd_valid dropped before the command was accepted");
                error_count++;
            end else if (cmd_held) begin
                check_cmd("cmd while held", cmd, cmd_saved);
            end
            if (data_held && !data_valid) begin
                $display("data_valid dropped before the byte was accepted");
                error_count++;
            end else if (data_held) begin
                check_byte("data while held", data, data_saved);
            end
            if (cmd_valid && cmd_ready) begin
                got_cmds.push_back(cmd);
                if (cmd.stop) begin
                    stop_seen = 1'b1;
                end
            end
            if (data_valid && data_ready) begin
                got_bytes.push_back(data);
                check_flag("data_last", data_last, 1'b1);
                check_flag("busy", busy, 1'b1);
            end
            cmd_held   = cmd_valid && !cmd_ready;
            data_held  = data_valid && !data_ready;
            cmd_saved  = cmd;
            data_saved = data;
        end
    end

    // walk the table from first with the opcode rules
    task automatic build_expected(input int first, input logic level);
        init_word_t words [TABLE_LEN];
        init_word_t w;
        i2c_cmd_t   c;
        i2c_addr_t  cur_addr;
        logic       start_next;
        logic       done;
        int         i;
        words = INIT_TABLE;
        // mic gain register, gain bit 6 with boost on, bit 2 with boost off
        words[BOOST_ENTRY] = {1'b1, (level ? 8'hea : 8'hae)};
        exp_cmds.delete();
        exp_bytes.delete();
        cur_addr   = '0;
        start_next = 1'b0;
        done       = 1'b0;
        i          = first;
        while (!done && i < TABLE_LEN) begin
            w = words[i];
            c = '{address: cur_addr, start: 1'b0, read: 1'b0, write: 1'b0,
                  write_multiple: 1'b0, stop: 1'b1};
            if (w[8]) begin
                c.start = start_next;
                c.write = 1'b1;
                c.stop  = 1'b0;
                exp_cmds.push_back(c);
                exp_bytes.push_back(w[7:0]);
                start_next = 1'b0;
            end else if (w[8:7] == 2'b01) begin
                cur_addr   = w[6:0];
                start_next = 1'b1;
            end else if (w == 9'b001000001) begin
                exp_cmds.push_back(c);
                start_next = 1'b0;
            end else if (w == 9'd0) begin
                exp_cmds.push_back(c);
                done = 1'b1;
            end
            i++;
        end
    endtask

    task automatic compare_lists(input int n);
        if (got_cmds.size() != exp_cmds.size()) begin
            $display("test %0d: %0d commands seen, %0d expected", n, got_cmds.size(),
                     exp_cmds.size());
            error_count++;
        end else begin
            foreach (exp_cmds[i]) begin
                check_cmd($sformatf("cmd[%0d]", i), got_cmds[i], exp_cmds[i]);
            end
        end
        if (got_bytes.size() != exp_bytes.size()) begin
            $display("test %0d: %0d data bytes seen, %0d expected", n, got_bytes.size(),
                     exp_bytes.size());
            error_count++;
        end else begin
            foreach (exp_bytes[i]) begin
                check_byte($sformatf("data[%0d]", i), got_bytes[i], exp_bytes[i]);
            end
        end
    endtask

    task automatic report_test(input int n, input int errs_before);
        tests_run++;
        if (error_count == errs_before) begin
            $display("test %0d passed", n);
        end else begin
            tests_failed++;
            $display("test %0d failed with %0d errors", n, error_count - errs_before);
        end
    endtask

    // no transfer and no busy without a start
    task automatic check_reset_idle();
        int errs_before;
        errs_before = error_count;
        check_flag("cmd_valid", cmd_valid, 1'b0);
        check_flag("data_valid", data_valid, 1'b0);
        check_flag("busy", busy, 1'b0);
        repeat (20) @(negedge clk);
        check_flag("busy", busy, 1'b0);
        if (got_cmds.size() != 0 || got_bytes.size() != 0) begin
            $display("transfer seen after reset without a start");
            error_count++;
        end
        report_test(0, errs_before);
    endtask

    task automatic apply_row(input int n);
        stim_row_t row;
        int        errs_before;
        row         = ROWS[n];
        errs_before = error_count;
        got_cmds.delete();
        got_bytes.delete();
        stop_seen = 1'b0;
        if (row.action == ACT_BOOST) begin
            boost_level = row.level;
        end
        build_expected(row.first, boost_level);
        @(posedge clk);
        rand_ready = row.rand_ready;
        @(negedge clk);
        case (row.action)
            ACT_PULSE: begin
                init_start = 1'b1;
                @(negedge clk);
                init_start = 1'b0;
            end
            ACT_HOLD: begin
                init_start = 1'b1;
            end
            default: begin
                mic_boost = row.level;
            end
        endcase
        // run ends on the accepted final stop
        while (!stop_seen) @(negedge clk);
        check_flag("busy", busy, 1'b0);
        check_flag("cmd_valid", cmd_valid, 1'b0);
        check_flag("data_valid", data_valid, 1'b0);
        if (row.action == ACT_HOLD) begin
            // held start must not trigger a second run
            repeat (HOLD_CYCLES) @(negedge clk);
            init_start = 1'b0;
        end
        repeat (4) @(negedge clk);
        compare_lists(n + 1);
        report_test(n + 1, errs_before);
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout, run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        seed         = 32'h610555e0;
        rst          = 1'b1;
        init_start   = 1'b0;
        mic_boost    = 1'b0;
        cmd_ready    = 1'b1;
        data_ready   = 1'b1;
        rand_ready   = 1'b0;
        boost_level  = 1'b0;
        stop_seen    = 1'b0;
        error_count  = 0;
        tests_run    = 0;
        tests_failed = 0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;
        check_reset_idle();
        for (int n = 0; n < NUM_ROWS; n++) begin
            apply_row(n);
        end
        $display("%0d tests, %0d passed, %0d failed, %0d errors", tests_run,
                 tests_run - tests_failed, tests_failed, error_count);
        if (error_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== i2c_init.sv ====
// audio board power-up configuration through an external I2C master
`timescale 1ns/1ps
`default_nettype none

module i2c_init #(
    parameter int TABLE_LEN     = 43,
    parameter int BOOST_ENTRY   = 41,
    parameter int BOOST_RESTART = 39
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   init_start,
    input  logic                   mic_boost,
    output i2c_cmd_pkg::i2c_cmd_t  cmd,
    output logic                   cmd_valid,
    input  logic                   cmd_ready,
    output i2c_cmd_pkg::i2c_byte_t data,
    output logic                   data_valid,
    input  logic                   data_ready,
    output logic                   data_last,
    output logic                   busy
);

    import init_seq_pkg::*;
    import i2c_cmd_pkg::*;

    localparam int IDX_W = $clog2(TABLE_LEN);

    logic [IDX_W-1:0] rd_index;
    init_op_e         op;
    i2c_addr_t        op_addr;
    i2c_byte_t        op_byte;
    logic             boost_restart;
    logic             pending;
    logic             issue_write;
    logic             issue_stop;
    logic             load_addr;
    i2c_addr_t        addr;
    i2c_byte_t        byte_out;
    i2c_cmd_t         cmd_core;

    init_rom #(
        .TABLE_LEN   (TABLE_LEN),
        .BOOST_ENTRY (BOOST_ENTRY)
    ) u_rom (
        .clk           (clk),
        .rst           (rst),
        .mic_boost     (mic_boost),
        .rd_index      (rd_index),
        .op            (op),
        .op_addr       (op_addr),
        .op_byte       (op_byte),
        .boost_restart (boost_restart)
    );

    init_sequencer #(
        .TABLE_LEN     (TABLE_LEN),
        .BOOST_RESTART (BOOST_RESTART)
    ) u_seq (
        .clk           (clk),
        .rst           (rst),
        .init_start    (init_start),
        .boost_restart (boost_restart),
        .op            (op),
        .op_addr       (op_addr),
        .op_byte       (op_byte),
        .pending       (pending),
        .rd_index      (rd_index),
        .issue_write   (issue_write),
        .issue_stop    (issue_stop),
        .load_addr     (load_addr),
        .addr          (addr),
        .byte_out      (byte_out),
        .busy          (busy)
    );

    i2c_cmd_out u_out (
        .clk         (clk),
        .rst         (rst),
        .issue_write (issue_write),
        .issue_stop  (issue_stop),
        .load_addr   (load_addr),
        .addr        (addr),
        .byte_out    (byte_out),
        .cmd_ready   (cmd_ready),
        .data_ready  (data_ready),
        .cmd         (cmd_core),
        .cmd_valid   (cmd_valid),
        .data        (data),
        .data_valid  (data_valid),
        .pending     (pending)
    );

    // single byte writes only, no reads and no burst mode
    always_comb begin
        cmd                = cmd_core;
        cmd.read           = 1'b0;
        cmd.write_multiple = 1'b0;
    end

    // every data byte closes its own transfer
    assign data_last = 1'b1;

endmodule

`default_nettype wire

// ==== i2c_cmd_out.sv ====
// result stage, holds command and data until the master accepts them
`timescale 1ns/1ps
`default_nettype none

module i2c_cmd_out (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   issue_write,
    input  logic                   issue_stop,
    input  logic                   load_addr,
    input  i2c_cmd_pkg::i2c_addr_t addr,
    input  i2c_cmd_pkg::i2c_byte_t byte_out,
    input  logic                   cmd_ready,
    input  logic                   data_ready,
    output i2c_cmd_pkg::i2c_cmd_t  cmd,
    output logic                   cmd_valid,
    output i2c_cmd_pkg::i2c_byte_t data,
    output logic                   data_valid,
    output logic                   pending
);

    import i2c_cmd_pkg::*;

    i2c_addr_t addr_q;
    // set by an address word, cleared once a command is taken
    logic      start_q;

    // payload, loaded on a strobe and held while valid
    always_ff @(posedge clk) begin
        if (load_addr) begin
            addr_q <= addr;
        end
        if (issue_write) begin
            cmd  <= '{address: addr_q, start: start_q, read: 1'b0, write: 1'b1,
                      write_multiple: 1'b0, stop: 1'b0};
            data <= byte_out;
        end else if (issue_stop) begin
            cmd  <= '{address: addr_q, start: 1'b0, read: 1'b0, write: 1'b0,
                      write_multiple: 1'b0, stop: 1'b1};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            start_q    <= 1'b0;
            cmd_valid  <= 1'b0;
            data_valid <= 1'b0;
        end else begin
            if (load_addr) begin
                start_q <= 1'b1;
            end else if (cmd_valid && cmd_ready) begin
                start_q <= 1'b0;
            end
            // write uses both channels, stop only the command channel
            if (issue_write || issue_stop) begin
                cmd_valid <= 1'b1;
            end else if (cmd_ready) begin
                cmd_valid <= 1'b0;
            end
            if (issue_write) begin
                data_valid <= 1'b1;
            end else if (data_ready) begin
                data_valid <= 1'b0;
            end
        end
    end

    // back-pressure toward the sequencer
    assign pending = cmd_valid | data_valid;

endmodule

`default_nettype wire

// ==== init_sequencer.sv ====
// execute stage, steps through the table and raises output requests
`timescale 1ns/1ps
`default_nettype none

module init_sequencer #(
    parameter int TABLE_LEN     = 43,
    parameter int BOOST_RESTART = 39
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           init_start,
    input  logic                           boost_restart,
    input  init_seq_pkg::init_op_e         op,
    input  i2c_cmd_pkg::i2c_addr_t         op_addr,
    input  i2c_cmd_pkg::i2c_byte_t         op_byte,
    input  logic                           pending,
    output logic [$clog2(TABLE_LEN)-1:0]   rd_index,
    output logic                           issue_write,
    output logic                           issue_stop,
    output logic                           load_addr,
    output i2c_cmd_pkg::i2c_addr_t         addr,
    output i2c_cmd_pkg::i2c_byte_t         byte_out,
    output logic                           busy
);

    import init_seq_pkg::*;

    localparam int IDX_W = $clog2(TABLE_LEN);

    seq_state_e       state_q;
    seq_state_e       state_d;
    logic [IDX_W-1:0] index_q;
    logic [IDX_W-1:0] index_d;
    // start already consumed, cleared when init_start drops
    logic             start_flag_q;
    logic             accept;

    always_comb begin
        state_d     = state_q;
        index_d     = index_q;
        issue_write = 1'b0;
        issue_stop  = 1'b0;
        load_addr   = 1'b0;
        accept      = 1'b0;
        // output registers still full, hold everything
        if (!pending) begin
            case (state_q)
                SEQ_IDLE: begin
                    if ((init_start && !start_flag_q) || boost_restart) begin
                        accept  = 1'b1;
                        // boost replay only rewrites the mic gain register
                        index_d = boost_restart ? IDX_W'(BOOST_RESTART) : '0;
                        state_d = SEQ_RUN;
                    end
                end
                SEQ_RUN: begin
                    case (op)
                        OP_ADDR: begin
                            load_addr = 1'b1;
                            index_d   = index_q + 1'b1;
                        end
                        OP_DATA: begin
                            issue_write = 1'b1;
                            index_d     = index_q + 1'b1;
                        end
                        OP_STOP: begin
                            issue_stop = 1'b1;
                            index_d    = index_q + 1'b1;
                        end
                        OP_END: begin
                            // final stop, index stays on the end word
                            issue_stop = 1'b1;
                            state_d    = SEQ_IDLE;
                        end
                        default: begin
                            index_d = index_q + 1'b1;
                        end
                    endcase
                end
                default: begin
                    state_d = SEQ_IDLE;
                end
            endcase
        end
    end

    // rom reads the next index so op is ready a cycle later
    assign rd_index = index_d;
    assign addr     = op_addr;
    assign byte_out = op_byte;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q      <= SEQ_IDLE;
            index_q      <= '0;
            start_flag_q <= 1'b0;
            busy         <= 1'b0;
        end else begin
            state_q      <= state_d;
            index_q      <= index_d;
            start_flag_q <= init_start && (start_flag_q || accept);
            // busy trails the state by a cycle
            busy         <= (state_q != SEQ_IDLE);
        end
    end

endmodule

`default_nettype wire

// ==== init_rom.sv ====
// decode stage, configuration table with boost patch and command decode
`timescale 1ns/1ps
`default_nettype none

module init_rom #(
    parameter int TABLE_LEN   = 43,
    parameter int BOOST_ENTRY = 41
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           mic_boost,
    input  logic [$clog2(TABLE_LEN)-1:0]   rd_index,
    output init_seq_pkg::init_op_e         op,
    output i2c_cmd_pkg::i2c_addr_t         op_addr,
    output i2c_cmd_pkg::i2c_byte_t         op_byte,
    output logic                           boost_restart
);

    import init_seq_pkg::*;

    `include "init_table.svh"

    // table length follows the header contents
    init_word_t table_mem [TABLE_LEN] = INIT_TABLE;
    init_word_t word_q;

    logic       boost_prev;
    logic       boost_change;
    logic [7:0] patch_byte;

    // last sampled boost level for the edge detect
    always_ff @(posedge clk) begin
        boost_prev <= mic_boost;
    end

    assign boost_change = mic_boost ^ boost_prev;
    assign patch_byte   = BOOST_BASE | (mic_boost ? BOOST_ON_BITS : BOOST_OFF_BITS);

    // patch lands before the replay can reach the boost entry
    always_ff @(posedge clk) begin
        if (boost_change) begin
            table_mem[BOOST_ENTRY] <= {1'b1, patch_byte};
        end
        // registered read, op follows rd_index by one cycle
        word_q <= table_mem[rd_index];
    end

    // one cycle replay request
    always_ff @(posedge clk) begin
        if (rst) begin
            boost_restart <= 1'b0;
        end else begin
            boost_restart <= boost_change;
        end
    end

    // classify the held word
    always_comb begin
        op_addr = word_q[6:0];
        op_byte = word_q[7:0];
        if (word_q[8]) begin
            op = OP_DATA;
        end else if (word_q[8:7] == ADDR_PREFIX) begin
            op = OP_ADDR;
        end else if (word_q == WORD_STOP) begin
            op = OP_STOP;
        end else if (word_q == WORD_END) begin
            op = OP_END;
        end else begin
            // unknown words, old multi-device codes too
            op = OP_SKIP;
        end
    end

endmodule

`default_nettype wire

// ==== init_seq_pkg.sv ====
// table word format, opcodes and sequencer state for the init sequencer
`default_nettype none

package init_seq_pkg;

    // one configuration table entry
    // 1 dddddddd  data byte
    // 01 aaaaaaa  start write to address
    typedef logic [8:0] init_word_t;

    // decoded table word
    typedef enum logic [2:0] {
        OP_END  = 3'd0,
        OP_ADDR = 3'd1,
        OP_DATA = 3'd2,
        OP_STOP = 3'd3,
        OP_SKIP = 3'd4
    } init_op_e;

    // run control
    typedef enum logic {
        SEQ_IDLE = 1'b0,
        SEQ_RUN  = 1'b1
    } seq_state_e;

    // end of table, closes the bus and ends the run
    localparam init_word_t WORD_END = 9'b000000000;
    // explicit I2C stop in the middle of the table
    localparam init_word_t WORD_STOP = 9'b001000001;
    // top two bits of an address word
    localparam logic [1:0] ADDR_PREFIX = 2'b01;

    // codec mic gain register, fixed bits
    localparam logic [7:0] BOOST_BASE = 8'haa;
    // gain bits with boost on
    localparam logic [7:0] BOOST_ON_BITS = 8'h40;
    // gain bits with boost off
    localparam logic [7:0] BOOST_OFF_BITS = 8'h04;

endpackage

`default_nettype wire

// ==== i2c_cmd_pkg.sv ====
// command and data channel types toward the external I2C master
`default_nettype none

package i2c_cmd_pkg;

    // 7-bit bus address of a target device
    typedef logic [6:0] i2c_addr_t;

    // one byte on the data channel
    typedef logic [7:0] i2c_byte_t;

    // one master command
    // start opens a transfer to address, stop closes the bus
    // read and write_multiple exist on the master but are not used here
    typedef struct packed {
        i2c_addr_t address;
        logic      start;
        logic      read;
        logic      write;
        logic      write_multiple;
        logic      stop;
    } i2c_cmd_t;

endpackage

`default_nettype wire

// ==== init_table.svh ====
// power-up configuration table for the clock chip and the audio codec

// 43 entries, address word then register and value
localparam init_seq_pkg::init_word_t INIT_TABLE [43] = '{
    // clock chip at 6ah
    {2'b01, 7'h6a},
    {1'b1, 8'h17},
    {1'b1, 8'h04},
    {2'b01, 7'h6a},
    {1'b1, 8'h18},
    {1'b1, 8'h40},
    {2'b01, 7'h6a},
    {1'b1, 8'h1e},
    {1'b1, 8'he8},
    {2'b01, 7'h6a},
    {1'b1, 8'h1f},
    {1'b1, 8'h80},
    {2'b01, 7'h6a},
    {1'b1, 8'h2d},
    {1'b1, 8'h01},
    {2'b01, 7'h6a},
    {1'b1, 8'h2e},
    {1'b1, 8'h10},
    // output divider setup
    {2'b01, 7'h6a},
    {1'b1, 8'h60},
    {1'b1, 8'h3b},
    // codec at 12h, dummy write first to wake the interface
    {2'b01, 7'h12},
    {1'b1, 8'h00},
    {1'b1, 8'h00},
    // mode control 1, pll and audio format
    {2'b01, 7'h12},
    {1'b1, 8'h05},
    {1'b1, 8'h33},
    // power management 1, vcom dac and adc
    {2'b01, 7'h12},
    {1'b1, 8'h00},
    {1'b1, 8'hc5},
    // power management 2, osc pll and speaker
    {2'b01, 7'h12},
    {1'b1, 8'h01},
    {1'b1, 8'hb6},
    // signal select 3
    {2'b01, 7'h12},
    {1'b1, 8'h04},
    {1'b1, 8'h47},
    // signal select 2, speaker gain
    {2'b01, 7'h12},
    {1'b1, 8'h03},
    {1'b1, 8'h80},
    // signal select 1, mic gain, last byte patched by boost
    {2'b01, 7'h12},
    {1'b1, 8'h02},
    {1'b1, 8'hae},
    // end of table
    9'd0
};
